/* hw/rv_pkg.sv */
package rv_pkg;

  // register width
  localparam int xlen = 64;

  typedef logic [xlen-1:0] xlen_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_addr_t;

  // one-hot alu selection
  localparam int alu_width = 10;

  typedef logic [alu_width-1:0] alu_sel_t;

  // bit positions inside alu_sel_t
  localparam int alu_add  = 0;
  localparam int alu_sub  = 1;
  localparam int alu_slt  = 2;
  localparam int alu_sltu = 3;
  localparam int alu_xor  = 4;
  localparam int alu_or   = 5;
  localparam int alu_and  = 6;
  localparam int alu_sll  = 7;
  localparam int alu_srl  = 8;
  localparam int alu_sra  = 9;

  // major opcodes accepted by the core
  localparam logic [6:0] op_imm    = 7'h13;
  localparam logic [6:0] op_imm_32 = 7'h1b;
  localparam logic [6:0] op_reg    = 7'h33;
  localparam logic [6:0] op_reg_32 = 7'h3b;
  localparam logic [6:0] op_lui    = 7'h37;
  localparam logic [6:0] op_auipc  = 7'h17;

  // funct3 codes
  localparam logic [2:0] f3_add  = 3'h0;
  localparam logic [2:0] f3_sll  = 3'h1;
  localparam logic [2:0] f3_slt  = 3'h2;
  localparam logic [2:0] f3_sltu = 3'h3;
  localparam logic [2:0] f3_xor  = 3'h4;
  localparam logic [2:0] f3_sr   = 3'h5;
  localparam logic [2:0] f3_or   = 3'h6;
  localparam logic [2:0] f3_and  = 3'h7;

  // funct7 codes, upper six bits double as funct6
  localparam logic [6:0] f7_base = 7'h00;
  localparam logic [6:0] f7_alt  = 7'h20;

endpackage

/* hw/inst_decode.sv */
`timescale 1ns/1ns

module inst_decode (
  input  logic              clk,
  input  logic              rst,
  input  logic              inst_valid,
  output logic              inst_allowin,
  input  rv_pkg::inst_t     inst,
  input  rv_pkg::xlen_t     pc,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::xlen_t     rs1_data,
  input  rv_pkg::xlen_t     rs2_data,
  output logic              dec_valid,
  output rv_pkg::xlen_t     dec_pc,
  output rv_pkg::xlen_t     dec_op1,
  output rv_pkg::xlen_t     dec_op2,
  output rv_pkg::alu_sel_t  dec_alu_sel,
  output logic              dec_word,
  output rv_pkg::reg_addr_t dec_rd,
  output logic              dec_rd_wen,
  output logic              dec_illegal
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [5:0]        funct6;
  rv_pkg::reg_addr_t rd;
  rv_pkg::xlen_t     imm_i;
  rv_pkg::xlen_t     imm_u;
  logic              is_imm, is_imm32, is_reg, is_reg32, is_lui, is_auipc;
  logic              f7_is_base, f7_is_alt, f6_is_base, f6_is_alt;
  logic              f3_is_sll, f3_is_sr, f3_is_add;
  logic              imm_ok, imm32_ok, reg_ok, reg32_ok;
  logic              legal;
  logic              uses_rs1, uses_rs2;
  logic              hazard;
  logic              accept;
  rv_pkg::alu_sel_t  alu_sel;
  rv_pkg::xlen_t     op1, op2;

  // funct3 to one-hot; alt picks sub or sra
  function automatic rv_pkg::alu_sel_t f3_to_sel(logic [2:0] f3, logic alt);
    rv_pkg::alu_sel_t sel;
    sel = '0;
    case (f3)
      rv_pkg::f3_add:  sel[alt ? rv_pkg::alu_sub : rv_pkg::alu_add] = 1'b1;
      rv_pkg::f3_sll:  sel[rv_pkg::alu_sll] = 1'b1;
      rv_pkg::f3_slt:  sel[rv_pkg::alu_slt] = 1'b1;
      rv_pkg::f3_sltu: sel[rv_pkg::alu_sltu] = 1'b1;
      rv_pkg::f3_xor:  sel[rv_pkg::alu_xor] = 1'b1;
      rv_pkg::f3_sr:   sel[alt ? rv_pkg::alu_sra : rv_pkg::alu_srl] = 1'b1;
      rv_pkg::f3_or:   sel[rv_pkg::alu_or] = 1'b1;
      default:         sel[rv_pkg::alu_and] = 1'b1;
    endcase
    return sel;
  endfunction

  // instruction fields
  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign funct6   = inst[31:26];
  assign rd       = inst[11:7];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign imm_i    = {{52{inst[31]}}, inst[31:20]};
  assign imm_u    = {{32{inst[31]}}, inst[31:12], 12'b0};

  assign is_imm   = (opcode == rv_pkg::op_imm);
  assign is_imm32 = (opcode == rv_pkg::op_imm_32);
  assign is_reg   = (opcode == rv_pkg::op_reg);
  assign is_reg32 = (opcode == rv_pkg::op_reg_32);
  assign is_lui   = (opcode == rv_pkg::op_lui);
  assign is_auipc = (opcode == rv_pkg::op_auipc);

  assign f7_is_base = (funct7 == rv_pkg::f7_base);
  assign f7_is_alt  = (funct7 == rv_pkg::f7_alt);
  assign f6_is_base = (funct6 == rv_pkg::f7_base[6:1]);
  assign f6_is_alt  = (funct6 == rv_pkg::f7_alt[6:1]);
  assign f3_is_add  = (funct3 == rv_pkg::f3_add);
  assign f3_is_sll  = (funct3 == rv_pkg::f3_sll);
  assign f3_is_sr   = (funct3 == rv_pkg::f3_sr);

  // per-format legality
  assign imm_ok   = f3_is_sll ? f6_is_base :
                    f3_is_sr  ? (f6_is_base | f6_is_alt) : 1'b1;
  assign imm32_ok = f3_is_add | (f3_is_sll & f7_is_base) |
                    (f3_is_sr & (f7_is_base | f7_is_alt));
  assign reg_ok   = (f3_is_add | f3_is_sr) ? (f7_is_base | f7_is_alt) : f7_is_base;
  assign reg32_ok = ((f3_is_add | f3_is_sr) & (f7_is_base | f7_is_alt)) |
                    (f3_is_sll & f7_is_base);

  assign legal = (is_imm & imm_ok) | (is_imm32 & imm32_ok) | (is_reg & reg_ok) |
                 (is_reg32 & reg32_ok) | is_lui | is_auipc;

  always_comb begin
    alu_sel = '0;
    if (is_lui || is_auipc) begin
      alu_sel[rv_pkg::alu_add] = 1'b1;
    end else if (is_imm) begin
      alu_sel = f3_to_sel(funct3, f3_is_sr & f6_is_alt);
    end else if (is_imm32) begin
      alu_sel = f3_to_sel(funct3, f3_is_sr & f7_is_alt);
    end else if (is_reg || is_reg32) begin
      alu_sel = f3_to_sel(funct3, f7_is_alt);
    end
    if (!legal) begin
      alu_sel = '0;
    end
  end

  // operand select, word forms keep only the low half of registers
  always_comb begin
    if (is_lui) begin
      op1 = '0;
    end else if (is_auipc) begin
      op1 = pc;
    end else if (is_imm32 || is_reg32) begin
      op1 = {32'b0, rs1_data[31:0]};
    end else begin
      op1 = rs1_data;
    end

    if (is_lui || is_auipc) begin
      op2 = imm_u;
    end else if (is_imm || is_imm32) begin
      op2 = imm_i;
    end else if (is_reg32) begin
      op2 = {32'b0, rs2_data[31:0]};
    end else begin
      op2 = rs2_data;
    end
  end

  // raw hazard against the instruction held for execute
  assign uses_rs1 = legal & (is_imm | is_imm32 | is_reg | is_reg32);
  assign uses_rs2 = legal & (is_reg | is_reg32);
  assign hazard   = inst_valid & dec_valid & dec_rd_wen & (dec_rd != '0) &
                    ((uses_rs1 & (rs1_addr == dec_rd)) | (uses_rs2 & (rs2_addr == dec_rd)));

  // execute never back-pressures, so only the hazard blocks
  assign inst_allowin = ~hazard;
  assign accept       = inst_valid & inst_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec_pc      <= pc;
      dec_op1     <= op1;
      dec_op2     <= op2;
      dec_alu_sel <= alu_sel;
      dec_word    <= is_imm32 | is_reg32;
      dec_rd      <= rd;
      dec_rd_wen  <= legal;
      dec_illegal <= ~legal;
    end
  end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::xlen_t     rs1_data,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::xlen_t     rs2_data,
  input  logic              wr_en,
  input  rv_pkg::reg_addr_t wr_addr,
  input  rv_pkg::xlen_t     wr_data
);

  // x1..x31, x0 is not stored
  rv_pkg::xlen_t regs [1:31];

  // read with write-through bypass
  function automatic rv_pkg::xlen_t read_port(rv_pkg::reg_addr_t addr);
    rv_pkg::xlen_t data;
    if (addr == '0) begin
      data = '0;
    end else if (wr_en && (wr_addr == addr)) begin
      data = wr_data;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

/* hw/alu_stage.sv */
`timescale 1ns/1ns

module alu_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              dec_valid,
  input  rv_pkg::xlen_t     dec_pc,
  input  rv_pkg::xlen_t     dec_op1,
  input  rv_pkg::xlen_t     dec_op2,
  input  rv_pkg::alu_sel_t  dec_alu_sel,
  input  logic              dec_word,
  input  rv_pkg::reg_addr_t dec_rd,
  input  logic              dec_rd_wen,
  input  logic              dec_illegal,
  output logic              exe_valid,
  output rv_pkg::xlen_t     exe_pc,
  output rv_pkg::xlen_t     exe_result,
  output rv_pkg::reg_addr_t exe_rd,
  output logic              exe_rd_wen,
  output logic              exe_illegal
);

  logic [5:0]    shamt;
  rv_pkg::xlen_t srl_src;
  rv_pkg::xlen_t sra_src;
  rv_pkg::xlen_t add_res, sub_res, slt_res, sltu_res;
  rv_pkg::xlen_t sll_res, srl_res, sra_res;
  rv_pkg::xlen_t raw;
  rv_pkg::xlen_t result;

  // word mode shifts by five bits only
  assign shamt = dec_word ? {1'b0, dec_op2[4:0]} : dec_op2[5:0];

  // word right shifts see only the low 32 bits
  assign srl_src = dec_word ? {32'b0, dec_op1[31:0]} : dec_op1;
  assign sra_src = dec_word ? {{32{dec_op1[31]}}, dec_op1[31:0]} : dec_op1;

  assign add_res  = dec_op1 + dec_op2;
  assign sub_res  = dec_op1 - dec_op2;
  assign slt_res  = {63'b0, ($signed(dec_op1) < $signed(dec_op2))};
  assign sltu_res = {63'b0, (dec_op1 < dec_op2)};
  assign sll_res  = dec_op1 << shamt;
  assign srl_res  = srl_src >> shamt;
  assign sra_res  = $signed(sra_src) >>> shamt;

  // one-hot and-or mux
  assign raw = ({64{dec_alu_sel[rv_pkg::alu_add]}}  & add_res)
             | ({64{dec_alu_sel[rv_pkg::alu_sub]}}  & sub_res)
             | ({64{dec_alu_sel[rv_pkg::alu_slt]}}  & slt_res)
             | ({64{dec_alu_sel[rv_pkg::alu_sltu]}} & sltu_res)
             | ({64{dec_alu_sel[rv_pkg::alu_xor]}}  & (dec_op1 ^ dec_op2))
             | ({64{dec_alu_sel[rv_pkg::alu_or]}}   & (dec_op1 | dec_op2))
             | ({64{dec_alu_sel[rv_pkg::alu_and]}}  & (dec_op1 & dec_op2))
             | ({64{dec_alu_sel[rv_pkg::alu_sll]}}  & sll_res)
             | ({64{dec_alu_sel[rv_pkg::alu_srl]}}  & srl_res)
             | ({64{dec_alu_sel[rv_pkg::alu_sra]}}  & sra_res);

  // sign-extend word results from bit 31
  assign result = dec_word ? {{32{raw[31]}}, raw[31:0]} : raw;

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid <= 1'b0;
    end else begin
      exe_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      exe_pc      <= dec_pc;
      exe_result  <= result;
      exe_rd      <= dec_rd;
      exe_rd_wen  <= dec_rd_wen;
      exe_illegal <= dec_illegal;
    end
  end

endmodule

/* hw/wb_stage.sv */
`timescale 1ns/1ns

module wb_stage (
  input  logic              exe_valid,
  input  rv_pkg::xlen_t     exe_pc,
  input  rv_pkg::xlen_t     exe_result,
  input  rv_pkg::reg_addr_t exe_rd,
  input  logic              exe_rd_wen,
  input  logic              exe_illegal,
  output logic              wr_en,
  output rv_pkg::reg_addr_t wr_addr,
  output rv_pkg::xlen_t     wr_data,
  output logic              retire_valid,
  output rv_pkg::xlen_t     retire_pc,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::xlen_t     retire_data,
  output logic              retire_illegal
);

  // no write for illegal encodings or x0
  assign wr_en   = exe_valid & exe_rd_wen & ~exe_illegal & (exe_rd != '0);
  assign wr_addr = exe_rd;
  assign wr_data = exe_result;

  // retire record, blanked for illegal encodings
  assign retire_valid   = exe_valid;
  assign retire_pc      = exe_pc;
  assign retire_illegal = exe_illegal;
  assign retire_rd      = exe_illegal ? '0 : exe_rd;
  assign retire_data    = exe_illegal ? '0 : exe_result;

endmodule

/* hw/int_core.sv */
`timescale 1ns/1ns

module int_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              inst_valid,
  output logic              inst_allowin,
  input  rv_pkg::inst_t     inst,
  input  rv_pkg::xlen_t     pc,
  output logic              retire_valid,
  output rv_pkg::xlen_t     retire_pc,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::xlen_t     retire_data,
  output logic              retire_illegal
);

  // register file read
  rv_pkg::reg_addr_t rs1_addr, rs2_addr;
  rv_pkg::xlen_t     rs1_data, rs2_data;

  // decode to execute
  logic              dec_valid;
  rv_pkg::xlen_t     dec_pc, dec_op1, dec_op2;
  rv_pkg::alu_sel_t  dec_alu_sel;
  logic              dec_word;
  rv_pkg::reg_addr_t dec_rd;
  logic              dec_rd_wen, dec_illegal;

  // execute to writeback
  logic              exe_valid;
  rv_pkg::xlen_t     exe_pc, exe_result;
  rv_pkg::reg_addr_t exe_rd;
  logic              exe_rd_wen, exe_illegal;

  // register file write
  logic              wr_en;
  rv_pkg::reg_addr_t wr_addr;
  rv_pkg::xlen_t     wr_data;

  inst_decode u_decode (
    .clk, .rst, .inst_valid, .inst_allowin, .inst, .pc,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .dec_valid, .dec_pc, .dec_op1, .dec_op2, .dec_alu_sel,
    .dec_word, .dec_rd, .dec_rd_wen, .dec_illegal
  );

  reg_file u_reg_file (
    .clk, .rst, .rs1_addr, .rs1_data, .rs2_addr, .rs2_data,
    .wr_en, .wr_addr, .wr_data
  );

  alu_stage u_alu (
    .clk, .rst, .dec_valid, .dec_pc, .dec_op1, .dec_op2, .dec_alu_sel,
    .dec_word, .dec_rd, .dec_rd_wen, .dec_illegal,
    .exe_valid, .exe_pc, .exe_result, .exe_rd, .exe_rd_wen, .exe_illegal
  );

  wb_stage u_wb (
    .exe_valid, .exe_pc, .exe_result, .exe_rd, .exe_rd_wen, .exe_illegal,
    .wr_en, .wr_addr, .wr_data,
    .retire_valid, .retire_pc, .retire_rd, .retire_data, .retire_illegal
  );

endmodule

/* verif/int_core_props.sv */
`timescale 1ns/1ns

module int_core_props (
  input logic              clk,
  input logic              rst,
  input logic              dec_valid,
  input logic              inst_allowin,
  input logic              retire_valid,
  input rv_pkg::reg_addr_t retire_rd,
  input logic              retire_illegal
);

  // pipeline is empty in the cycle after reset
  reset_empty: assert property (@(posedge clk) rst |=> !dec_valid && !retire_valid)
    else $error("pipeline not empty after reset");

  // only a held instruction can cause a stall
  allowin_when_empty: assert property (@(posedge clk) disable iff (rst)
    !dec_valid |-> inst_allowin)
    else $error("inst_allowin low with empty decode register");

  // illegal retires carry no destination
  illegal_rd_zero: assert property (@(posedge clk) disable iff (rst)
    retire_valid && retire_illegal |-> retire_rd == '0)
    else $error("illegal retire with nonzero rd");

endmodule

bind int_core int_core_props u_props (
  .clk, .rst, .dec_valid, .inst_allowin, .retire_valid, .retire_rd, .retire_illegal
);

/* verif/int_core_tb.sv */
`timescale 1ns/1ns

module int_core_tb;

  typedef struct {
    rv_pkg::xlen_t     pc;
    rv_pkg::reg_addr_t rd;
    rv_pkg::xlen_t     data;
    logic              illegal;
    int                due;
  } exp_t;

  logic              clk;
  logic              rst;
  logic              inst_valid;
  logic              inst_allowin;
  rv_pkg::inst_t     inst;
  rv_pkg::xlen_t     pc;
  logic              retire_valid;
  rv_pkg::xlen_t     retire_pc;
  rv_pkg::reg_addr_t retire_rd;
  rv_pkg::xlen_t     retire_data;
  logic              retire_illegal;

  rv_pkg::xlen_t model_regs [0:31];
  exp_t          exp_q [$];
  rv_pkg::xlen_t rng_state;
  rv_pkg::xlen_t cur_pc;
  string         test_name;
  int            cyc;
  int            stalls;

  int_core DUT (
    .clk, .rst, .inst_valid, .inst_allowin, .inst, .pc,
    .retire_valid, .retire_pc, .retire_rd, .retire_data, .retire_illegal
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_xlen(input string what, input rv_pkg::xlen_t exp,
                            input rv_pkg::xlen_t act);
    if (exp !== act) begin
      abort($sformatf("FAIL %s %s: expected %h actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_addr(input string what, input rv_pkg::reg_addr_t exp,
                            input rv_pkg::reg_addr_t act);
    if (exp !== act) begin
      abort($sformatf("FAIL %s %s: expected %0d actual %0d", test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      abort($sformatf("FAIL %s %s: expected %b actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (exp != act) begin
      abort($sformatf("FAIL %s %s: expected %0d actual %0d", test_name, what, exp, act));
    end
  endtask

  // xorshift64
  function automatic rv_pkg::xlen_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  function automatic rv_pkg::inst_t enc_i(logic [6:0] op, logic [2:0] f3,
                                          logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::inst_t enc_r(logic [6:0] op, logic [2:0] f3, logic [6:0] f7,
                                          logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::xlen_t sext32(logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  // reference model of one instruction against model_regs
  function automatic void ref_exec(input rv_pkg::inst_t i, input rv_pkg::xlen_t p,
                                   output rv_pkg::reg_addr_t rd, output rv_pkg::xlen_t data,
                                   output logic ill);
    rv_pkg::xlen_t a;
    rv_pkg::xlen_t b;
    rv_pkg::xlen_t imm;
    rv_pkg::xlen_t res;
    logic [31:0]   w;
    logic [6:0]    f7;
    a   = model_regs[i[19:15]];
    b   = model_regs[i[24:20]];
    imm = {{52{i[31]}}, i[31:20]};
    f7  = i[31:25];
    ill = 1'b0;
    res = '0;
    w   = '0;
    case (i[6:0])
      rv_pkg::op_imm: begin
        case (i[14:12])
          rv_pkg::f3_add:  res = a + imm;
          rv_pkg::f3_slt:  res = ($signed(a) < $signed(imm)) ? 64'd1 : 64'd0;
          rv_pkg::f3_sltu: res = (a < imm) ? 64'd1 : 64'd0;
          rv_pkg::f3_xor:  res = a ^ imm;
          rv_pkg::f3_or:   res = a | imm;
          rv_pkg::f3_and:  res = a & imm;
          rv_pkg::f3_sll:  begin
            ill = (i[31:26] != 6'h00);
            res = a << i[25:20];
          end
          default: begin
            ill = (i[31:26] != 6'h00) && (i[31:26] != 6'h10);
            if (i[30]) begin
              res = $signed(a) >>> i[25:20];
            end else begin
              res = a >> i[25:20];
            end
          end
        endcase
      end
      rv_pkg::op_imm_32: begin
        case (i[14:12])
          rv_pkg::f3_add: w = a[31:0] + imm[31:0];
          rv_pkg::f3_sll: begin
            ill = (f7 != 7'h00);
            w   = a[31:0] << i[24:20];
          end
          rv_pkg::f3_sr: begin
            ill = (f7 != 7'h00) && (f7 != 7'h20);
            if (f7[5]) begin
              w = $signed(a[31:0]) >>> i[24:20];
            end else begin
              w = a[31:0] >> i[24:20];
            end
          end
          default: ill = 1'b1;
        endcase
        res = sext32(w);
      end
      rv_pkg::op_reg: begin
        ill = (f7 != 7'h00);
        case (i[14:12])
          rv_pkg::f3_add: begin
            ill = (f7 != 7'h00) && (f7 != 7'h20);
            res = f7[5] ? a - b : a + b;
          end
          rv_pkg::f3_sr: begin
            ill = (f7 != 7'h00) && (f7 != 7'h20);
            if (f7[5]) begin
              res = $signed(a) >>> b[5:0];
            end else begin
              res = a >> b[5:0];
            end
          end
          rv_pkg::f3_sll:  res = a << b[5:0];
          rv_pkg::f3_slt:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          rv_pkg::f3_sltu: res = (a < b) ? 64'd1 : 64'd0;
          rv_pkg::f3_xor:  res = a ^ b;
          rv_pkg::f3_or:   res = a | b;
          default:         res = a & b;
        endcase
      end
      rv_pkg::op_reg_32: begin
        ill = (f7 != 7'h00) && (f7 != 7'h20);
        case (i[14:12])
          rv_pkg::f3_add: w = f7[5] ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
          rv_pkg::f3_sr: begin
            if (f7[5]) begin
              w = $signed(a[31:0]) >>> b[4:0];
            end else begin
              w = a[31:0] >> b[4:0];
            end
          end
          rv_pkg::f3_sll: begin
            ill = (f7 != 7'h00);
            w   = a[31:0] << b[4:0];
          end
          default: ill = 1'b1;
        endcase
        res = sext32(w);
      end
      rv_pkg::op_lui:   res = {{32{i[31]}}, i[31:12], 12'b0};
      rv_pkg::op_auipc: res = p + {{32{i[31]}}, i[31:12], 12'b0};
      default: ill = 1'b1;
    endcase
    rd   = ill ? 5'd0 : i[11:7];
    data = ill ? '0 : res;
  endfunction

  // drive one instruction and hold it until accepted
  task automatic send(input rv_pkg::inst_t word);
    exp_t e;
    int   waits;
    logic ok;
    @(negedge clk);
    inst_valid = 1'b1;
    inst       = word;
    pc         = cur_pc;
    waits      = 0;
    ok         = 1'b0;
    while (!ok) begin
      #1;
      ok = inst_allowin;
      if (!ok) begin
        stalls++;
        waits++;
        if (waits > 4) abort("instruction was never accepted by the core");
        @(negedge clk);
      end
    end
    e.pc  = cur_pc;
    e.due = cyc + 2;
    ref_exec(word, cur_pc, e.rd, e.data, e.illegal);
    if (!e.illegal && e.rd != 0) model_regs[e.rd] = e.data;
    exp_q.push_back(e);
    cur_pc = cur_pc + 4;
    @(posedge clk);
  endtask

  // stop driving and let the pipeline empty
  task automatic drain();
    int waits;
    @(negedge clk);
    inst_valid = 1'b0;
    waits = 0;
    while (exp_q.size() != 0) begin
      waits++;
      if (waits > 20) abort("expected retires never arrived");
      @(negedge clk);
    end
  endtask

  // compare each retire against the oldest expected record
  always @(negedge clk) begin
    exp_t e;
    if (!rst && retire_valid) begin
      if (exp_q.size() == 0) abort("retire seen with no instruction outstanding");
      e = exp_q.pop_front();
      check_xlen("pc", e.pc, retire_pc);
      check_addr("rd", e.rd, retire_rd);
      check_xlen("data", e.data, retire_data);
      check_flag("illegal", e.illegal, retire_illegal);
      check_count("retire cycle", e.due, cyc);
    end
  end

  initial begin
    #2_000_000;
    abort("simulation timed out");
  end

  initial begin
    rv_pkg::inst_t w;
    logic [2:0]    f3;
    logic          alt;
    int            tries;
    rv_pkg::reg_addr_t rd_tmp;
    rv_pkg::xlen_t d_tmp;
    logic          ill_tmp;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    cyc        = 0;
    stalls     = 0;
    rng_state  = 64'd78873;
    cur_pc     = 64'h8000_0000;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_name = "reset";
    repeat (3) begin
      @(negedge clk);
      check_flag("inst_allowin", 1'b1, inst_allowin);
      check_flag("retire_valid", 1'b0, retire_valid);
    end

    test_name = "imm_forms";
    for (int r = 1; r < 32; r++) begin
      send(enc_i(rv_pkg::op_imm, rv_pkg::f3_add, r, 0, next_rand()));
    end
    repeat (40) begin
      f3  = next_rand();
      alt = next_rand();
      case (next_rand() % 4)
        0: begin
          w = enc_i(rv_pkg::op_imm, f3, next_rand(), next_rand(), next_rand());
          if (f3 == rv_pkg::f3_sll) w[31:26] = 6'h00;
          if (f3 == rv_pkg::f3_sr) w[31:26] = alt ? 6'h10 : 6'h00;
        end
        1: begin
          f3 = (f3 % 3 == 0) ? rv_pkg::f3_add : (f3 % 3 == 1) ? rv_pkg::f3_sll : rv_pkg::f3_sr;
          w  = enc_i(rv_pkg::op_imm_32, f3, next_rand(), next_rand(), next_rand());
          if (f3 != rv_pkg::f3_add) w[31:25] = (alt && f3 == rv_pkg::f3_sr) ? 7'h20 : 7'h00;
        end
        2: w = {20'(next_rand()), 5'(next_rand()), rv_pkg::op_lui};
        default: w = {20'(next_rand()), 5'(next_rand()), rv_pkg::op_auipc};
      endcase
      send(w);
    end
    drain();

    test_name = "reg_forms";
    repeat (60) begin
      f3  = next_rand();
      alt = next_rand();
      if (next_rand() % 2 == 0) begin
        alt = alt && (f3 == rv_pkg::f3_add || f3 == rv_pkg::f3_sr);
        w = enc_r(rv_pkg::op_reg, f3, alt ? 7'h20 : 7'h00, next_rand(), next_rand(), next_rand());
      end else begin
        f3  = (f3 % 3 == 0) ? rv_pkg::f3_add : (f3 % 3 == 1) ? rv_pkg::f3_sll : rv_pkg::f3_sr;
        alt = alt && (f3 != rv_pkg::f3_sll);
        w = enc_r(rv_pkg::op_reg_32, f3, alt ? 7'h20 : 7'h00, next_rand(), next_rand(),
                  next_rand());
      end
      send(w);
    end
    drain();

    test_name = "dependency_chain";
    stalls = 0;
    for (int k = 0; k < 8; k++) begin
      send(enc_r(rv_pkg::op_reg, rv_pkg::f3_add, 7'h00, 5, 5, 9));
    end
    check_count("adjacent stalls", 7, stalls);
    stalls = 0;
    for (int k = 0; k < 8; k++) begin
      send(enc_i(rv_pkg::op_imm, rv_pkg::f3_add, (k % 2) ? 7 : 6, (k % 2) ? 7 : 6, k));
    end
    check_count("distance two stalls", 0, stalls);
    drain();

    test_name = "illegal";
    repeat (10) begin
      tries   = 0;
      ill_tmp = 1'b0;
      while (!ill_tmp) begin
        tries++;
        if (tries > 100) abort("no illegal encoding found by the generator");
        w = 32'(next_rand());
        ref_exec(w, cur_pc, rd_tmp, d_tmp, ill_tmp);
      end
      send(w);
      send(enc_i(rv_pkg::op_imm, rv_pkg::f3_add, 10, w[11:7], 0));
    end
    drain();

    test_name = "x0_writes";
    send(enc_i(rv_pkg::op_imm, rv_pkg::f3_add, 0, 5, 12'h123));
    send(enc_r(rv_pkg::op_reg, rv_pkg::f3_or, 7'h00, 0, 6, 7));
    send(enc_i(rv_pkg::op_imm, rv_pkg::f3_add, 8, 0, 0));
    send(enc_r(rv_pkg::op_reg, rv_pkg::f3_add, 7'h00, 9, 0, 0));
    drain();

    if (exp_q.size() != 0) begin
      abort("instructions left outstanding at end of run");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* project.f */
hw/rv_pkg.sv
hw/inst_decode.sv
hw/reg_file.sv
hw/alu_stage.sv
hw/wb_stage.sv
hw/int_core.sv
verif/int_core_props.sv
verif/int_core_tb.sv

/* Bender.yml */
package:
  name: int_core

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/inst_decode.sv
      - hw/reg_file.sv
      - hw/alu_stage.sv
      - hw/wb_stage.sv
      - hw/int_core.sv
  - target: test
    files:
      - verif/int_core_props.sv
      - verif/int_core_tb.sv
